// File: verilog/stepper_pkg.sv
package stepper_pkg;

  // Phase counter, top two bits select the full-step quadrant
  localparam int phase_w = 8;
  localparam int quad_msb = phase_w - 1;

  // Off timer and its settings
  localparam int timer_w = 10;

  // Blank and minimum-on timers
  localparam int short_w = 8;

  // Half bridges per driver, ordered a1, a2, b1, b2 from the MSB down
  localparam int n_half_bridges = 4;

  typedef logic [phase_w-1:0] phase_t;
  typedef logic [timer_w-1:0] off_t;
  typedef logic [short_w-1:0] short_t;

  // Coil decay mode
  // drive follows the polarity, fast swaps the sides, slow grounds the coil
  typedef enum logic [1:0] {
    decay_drive = 2'd0,
    decay_fast  = 2'd1,
    decay_slow  = 2'd2
  } decay_e;

endpackage

// File: verilog/coil_timer_if.sv
`timescale 1ns/1ps

// Timer handshake between one coil chopper and the bridge driver
interface coil_timer_if;

  // Start of an off period, a level from the bridge side
  logic off_start;

  // Decay mode for the coil's two half bridges
  stepper_pkg::decay_e decay;

  // Timer status flags, high while the matching counter is nonzero
  logic off_active;
  logic blank_active;
  logic min_on_active;

  modport chopper (
    input  off_start,
    output decay,
    output off_active,
    output blank_active,
    output min_on_active
  );

  modport bridge (
    output off_start,
    input  decay,
    input  off_active,
    input  blank_active,
    input  min_on_active
  );

endinterface

// File: verilog/step_decode.sv
`timescale 1ns/1ps

module step_decode (
  input  logic                clk,
  input  logic                resetn,
  input  logic                step,
  input  logic                dir,
  output stepper_pkg::phase_t phase_ct,
  output logic                pol_a1,
  output logic                pol_a2,
  output logic                pol_b1,
  output logic                pol_b2,
  output logic                pol_change_a,
  output logic                pol_change_b
);

  logic [2:0] step_r;
  logic [1:0] dir_r;
  logic       step_rise;
  logic       a_rev;
  logic       b_rev;
  logic       a_rev_q;
  logic       b_rev_q;

  // Two stages for metastability, the third holds the previous level
  assign step_rise = step_r[1] & ~step_r[2];

  always_ff @(posedge clk) begin
    if (!resetn) begin
      step_r   <= '0;
      dir_r    <= '0;
      phase_ct <= '0;
      a_rev_q  <= 1'b0;
      b_rev_q  <= 1'b0;
    end else begin
      step_r  <= {step_r[1:0], step};
      dir_r   <= {dir_r[0], dir};
      a_rev_q <= a_rev;
      b_rev_q <= b_rev;
      if (step_rise) begin
        phase_ct <= dir_r[1] ? phase_ct + 1'b1 : phase_ct - 1'b1;
      end
    end
  end

  // Quadrant walks the Gray order 00, 01, 11, 10 of {a_rev, b_rev}
  always_comb begin
    case (phase_ct[stepper_pkg::quad_msb -: 2])
      2'b00:   {a_rev, b_rev} = 2'b00;
      2'b01:   {a_rev, b_rev} = 2'b01;
      2'b10:   {a_rev, b_rev} = 2'b11;
      default: {a_rev, b_rev} = 2'b10;
    endcase
  end

  assign pol_a1 = ~a_rev;
  assign pol_a2 = a_rev;
  assign pol_b1 = ~b_rev;
  assign pol_b2 = b_rev;

  // One cycle pulse after a coil reverses
  assign pol_change_a = a_rev ^ a_rev_q;
  assign pol_change_b = b_rev ^ b_rev_q;

  // Gray order lets only one coil reverse per quadrant step
  one_coil_reverses: assert property (@(posedge clk) disable iff (!resetn)
    !(pol_change_a && pol_change_b));

endmodule

// File: verilog/coil_chopper.sv
`timescale 1ns/1ps

module coil_chopper (
  input  logic                clk,
  input  logic                resetn,
  input  logic                pol_change,
  input  stepper_pkg::off_t   off_time,
  input  stepper_pkg::off_t   fastdecay_threshold,
  input  stepper_pkg::short_t blank_time,
  input  stepper_pkg::short_t min_on_time,
  coil_timer_if.chopper       tmr
);

  stepper_pkg::off_t   off_tmr;
  stepper_pkg::short_t blank_tmr;
  stepper_pkg::short_t min_on_tmr;
  logic                off_expire;
  logic                on_restart;

  // Last cycle of the off period
  assign off_expire = (off_tmr == stepper_pkg::off_t'(1));

  // A new on period begins after the off time or on a polarity flip
  assign on_restart = off_expire | pol_change;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      off_tmr <= '0;
    end else if (tmr.off_start) begin
      off_tmr <= off_time;
    end else if (off_tmr != '0) begin
      off_tmr <= off_tmr - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      blank_tmr  <= '0;
      min_on_tmr <= '0;
    end else if (on_restart) begin
      blank_tmr  <= blank_time;
      min_on_tmr <= min_on_time;
    end else begin
      if (blank_tmr != '0) begin
        blank_tmr <= blank_tmr - 1'b1;
      end
      if (min_on_tmr != '0) begin
        min_on_tmr <= min_on_tmr - 1'b1;
      end
    end
  end

  assign tmr.off_active    = (off_tmr != '0);
  assign tmr.blank_active  = (blank_tmr != '0);
  assign tmr.min_on_active = (min_on_tmr != '0);

  // Fast decay covers the top of the off count, slow decay the rest
  always_comb begin
    if (off_tmr == '0) begin
      tmr.decay = stepper_pkg::decay_drive;
    end else if (off_tmr >= fastdecay_threshold) begin
      tmr.decay = stepper_pkg::decay_fast;
    end else begin
      tmr.decay = stepper_pkg::decay_slow;
    end
  end

  // The bridge side must never restart a running off period
  off_start_idle: assert property (@(posedge clk) disable iff (!resetn)
    tmr.off_start |-> !tmr.off_active);

endmodule

// File: verilog/bridge_driver.sv
`timescale 1ns/1ps

module bridge_driver (
  input  logic        clk,
  input  logic        resetn,
  input  logic        enable_in,
  input  logic        invert_highside,
  input  logic        invert_lowside,
  input  logic        analog_cmp_a,
  input  logic        analog_cmp_b,
  input  logic        pol_a1,
  input  logic        pol_a2,
  input  logic        pol_b1,
  input  logic        pol_b2,
  coil_timer_if.bridge tmr_a,
  coil_timer_if.bridge tmr_b,
  output logic [3:0]  gate_h,
  output logic [3:0]  gate_l,
  output logic        faultn
);

  localparam int nhb = stepper_pkg::n_half_bridges;

  logic           enable;
  logic           fault_a;
  logic           fault_b;
  logic [nhb-1:0] pol_vec;
  logic [nhb-1:0] hs_raw;
  logic [nhb-1:0] hs_on;
  logic [nhb-1:0] ls_on;

  // High side state for one half bridge from decay mode and polarity
  function automatic logic high_side(input stepper_pkg::decay_e mode, input logic pol);
    case (mode)
      stepper_pkg::decay_drive: return pol;
      stepper_pkg::decay_fast:  return !pol;
      default:                  return 1'b0;
    endcase
  endfunction

  always_ff @(posedge clk) begin
    if (!resetn) begin
      enable <= 1'b0;
    end else begin
      enable <= enable_in;
    end
  end

  // Peak current trip starts the off period once blanking is over
  assign tmr_a.off_start = analog_cmp_a & ~tmr_a.blank_active & ~tmr_a.off_active;
  assign tmr_b.off_start = analog_cmp_b & ~tmr_b.blank_active & ~tmr_b.off_active;

  // A trip inside the minimum on time means a shorted or overloaded coil
  assign fault_a = tmr_a.off_start & tmr_a.min_on_active;
  assign fault_b = tmr_b.off_start & tmr_b.min_on_active;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      faultn <= 1'b1;
    end else if (enable && (fault_a || fault_b)) begin
      faultn <= 1'b0;
    end
  end

  // MSB is a1, LSB is b2
  assign pol_vec = {pol_a1, pol_a2, pol_b1, pol_b2};

  always_comb begin
    for (int i = 0; i < nhb; i++) begin
      if (i >= nhb / 2) begin
        hs_raw[i] = high_side(tmr_a.decay, pol_vec[i]);
      end else begin
        hs_raw[i] = high_side(tmr_b.decay, pol_vec[i]);
      end
    end
  end

  // Disable or fault drops the high sides, disable also grounds every coil end
  assign hs_on = hs_raw & {nhb{enable & faultn}};
  assign ls_on = ~hs_raw | {nhb{~enable}};

  assign gate_h = hs_on ^ {nhb{invert_highside}};
  assign gate_l = ls_on ^ {nhb{invert_lowside}};

  // Shoot-through guard on the chopper decay and enable gating together
  no_shoot_through: assert property (@(posedge clk) disable iff (!resetn)
    (hs_on & ls_on) == '0);

endmodule

// File: verilog/stepper_top.sv
`timescale 1ns/1ps

module stepper_top (
  input  logic                clk,
  input  logic                resetn,
  input  logic                step,
  input  logic                dir,
  input  logic                enable_in,
  input  logic                analog_cmp_a,
  input  logic                analog_cmp_b,
  input  stepper_pkg::off_t   off_time,
  input  stepper_pkg::off_t   fastdecay_threshold,
  input  stepper_pkg::short_t blank_time,
  input  stepper_pkg::short_t min_on_time,
  input  logic                invert_highside,
  input  logic                invert_lowside,
  output stepper_pkg::phase_t phase_ct,
  output logic [3:0]          gate_h,
  output logic [3:0]          gate_l,
  output logic                faultn
);

  logic pol_a1;
  logic pol_a2;
  logic pol_b1;
  logic pol_b2;
  logic pol_change_a;
  logic pol_change_b;

  coil_timer_if coil_a ();
  coil_timer_if coil_b ();

  step_decode decode (
    .clk          (clk),
    .resetn       (resetn),
    .step         (step),
    .dir          (dir),
    .phase_ct     (phase_ct),
    .pol_a1       (pol_a1),
    .pol_a2       (pol_a2),
    .pol_b1       (pol_b1),
    .pol_b2       (pol_b2),
    .pol_change_a (pol_change_a),
    .pol_change_b (pol_change_b)
  );

  // Both coils share the timing configuration
  coil_chopper chop_a (
    .clk                 (clk),
    .resetn              (resetn),
    .pol_change          (pol_change_a),
    .off_time            (off_time),
    .fastdecay_threshold (fastdecay_threshold),
    .blank_time          (blank_time),
    .min_on_time         (min_on_time),
    .tmr                 (coil_a.chopper)
  );

  coil_chopper chop_b (
    .clk                 (clk),
    .resetn              (resetn),
    .pol_change          (pol_change_b),
    .off_time            (off_time),
    .fastdecay_threshold (fastdecay_threshold),
    .blank_time          (blank_time),
    .min_on_time         (min_on_time),
    .tmr                 (coil_b.chopper)
  );

  bridge_driver bridge (
    .clk             (clk),
    .resetn          (resetn),
    .enable_in       (enable_in),
    .invert_highside (invert_highside),
    .invert_lowside  (invert_lowside),
    .analog_cmp_a    (analog_cmp_a),
    .analog_cmp_b    (analog_cmp_b),
    .pol_a1          (pol_a1),
    .pol_a2          (pol_a2),
    .pol_b1          (pol_b1),
    .pol_b2          (pol_b2),
    .tmr_a           (coil_a.bridge),
    .tmr_b           (coil_b.bridge),
    .gate_h          (gate_h),
    .gate_l          (gate_l),
    .faultn          (faultn)
  );

endmodule

// File: testbench/stepper_tb.sv
`timescale 1ns/1ps

module stepper_tb;

  localparam int clk_period = 8;
  localparam int n_fields = 16;
  localparam int margin_cycles = 20;

  // One test step: inputs, hold length and the expected outputs after the hold
  typedef struct {
    logic                step;
    logic                dir;
    logic                enable;
    logic                cmp_a;
    logic                cmp_b;
    stepper_pkg::off_t   off_time;
    stepper_pkg::off_t   threshold;
    stepper_pkg::short_t blank_time;
    stepper_pkg::short_t min_on_time;
    logic                inv_h;
    logic                inv_l;
    int                  hold;
    stepper_pkg::phase_t phase;
    logic [3:0]          gate_h;
    logic [3:0]          gate_l;
    logic                faultn;
  } record_t;

  logic                clk = 1'b0;
  logic                resetn;
  logic                step;
  logic                dir;
  logic                enable_in;
  logic                analog_cmp_a;
  logic                analog_cmp_b;
  stepper_pkg::off_t   off_time;
  stepper_pkg::off_t   fastdecay_threshold;
  stepper_pkg::short_t blank_time;
  stepper_pkg::short_t min_on_time;
  logic                invert_highside;
  logic                invert_lowside;
  stepper_pkg::phase_t phase_ct;
  logic [3:0]          gate_h;
  logic [3:0]          gate_l;
  logic                faultn;

  record_t recs[$];
  int      limit_cycles = 0;

  always #(clk_period / 2) clk = ~clk;

  stepper_top UUT (.*);

  task automatic stop_with_failure();
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic check_phase(input stepper_pkg::phase_t exp, input stepper_pkg::phase_t act);
    if (act !== exp) begin
      $display("mismatch at time %0t: phase_ct expected %h, actual %h", $time, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_gates(input logic [3:0] exp_h, input logic [3:0] exp_l,
                             input logic [3:0] act_h, input logic [3:0] act_l);
    if (act_h !== exp_h) begin
      $display("mismatch at time %0t: gate_h expected %h, actual %h", $time, exp_h, act_h);
      stop_with_failure();
    end else if (act_l !== exp_l) begin
      $display("mismatch at time %0t: gate_l expected %h, actual %h", $time, exp_l, act_l);
      stop_with_failure();
    end
  endtask

  task automatic check_fault(input logic exp, input logic act);
    if (act !== exp) begin
      $display("mismatch at time %0t: faultn expected %b, actual %b", $time, exp, act);
      stop_with_failure();
    end
  endtask

  // Lines starting with # are comments, all other lines are records
  task automatic load_records();
    int          fd;
    int          line_no;
    int          n;
    string       line;
    logic [31:0] f [n_fields];
    record_t     r;
    fd = $fopen("testbench/stepper_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open the test file testbench/stepper_tests.txt");
      stop_with_failure();
    end else begin
      line_no = 0;
      while ($fgets(line, fd) != 0) begin
        line_no++;
        if (line.len() > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %d %h %h %h %h",
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                      f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]);
          if (n != n_fields) begin
            $display("test file line %0d is malformed, read %0d of %0d fields",
                     line_no, n, n_fields);
            stop_with_failure();
          end else begin
            r.step        = f[0][0];
            r.dir         = f[1][0];
            r.enable      = f[2][0];
            r.cmp_a       = f[3][0];
            r.cmp_b       = f[4][0];
            r.off_time    = f[5][stepper_pkg::timer_w-1:0];
            r.threshold   = f[6][stepper_pkg::timer_w-1:0];
            r.blank_time  = f[7][stepper_pkg::short_w-1:0];
            r.min_on_time = f[8][stepper_pkg::short_w-1:0];
            r.inv_h       = f[9][0];
            r.inv_l       = f[10][0];
            r.hold        = f[11];
            r.phase       = f[12][stepper_pkg::phase_w-1:0];
            r.gate_h      = f[13][3:0];
            r.gate_l      = f[14][3:0];
            r.faultn      = f[15][0];
            recs.push_back(r);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic apply_record(input record_t r);
    step                <= r.step;
    dir                 <= r.dir;
    enable_in           <= r.enable;
    analog_cmp_a        <= r.cmp_a;
    analog_cmp_b        <= r.cmp_b;
    off_time            <= r.off_time;
    fastdecay_threshold <= r.threshold;
    blank_time          <= r.blank_time;
    min_on_time         <= r.min_on_time;
    invert_highside     <= r.inv_h;
    invert_lowside      <= r.inv_l;
  endtask

  initial begin
    int total;
    resetn              = 1'b0;
    step                = 1'b0;
    dir                 = 1'b0;
    enable_in           = 1'b0;
    analog_cmp_a        = 1'b0;
    analog_cmp_b        = 1'b0;
    off_time            = '0;
    fastdecay_threshold = '0;
    blank_time          = '0;
    min_on_time         = '0;
    invert_highside     = 1'b0;
    invert_lowside      = 1'b0;
    load_records();
    if (recs.size() == 0) begin
      $display("the test file holds no records");
      stop_with_failure();
    end else begin
      // Each record also spends its drive edge and half a cycle before the check
      total = 2;
      foreach (recs[i]) begin
        total += recs[i].hold + 2;
      end
      limit_cycles = total + margin_cycles;
      repeat (2) @(posedge clk);
      resetn <= 1'b1;
      foreach (recs[i]) begin
        @(posedge clk);
        apply_record(recs[i]);
        repeat (recs[i].hold) @(posedge clk);
        @(negedge clk);
        check_phase(recs[i].phase, phase_ct);
        check_gates(recs[i].gate_h, recs[i].gate_l, gate_h, gate_l);
        check_fault(recs[i].faultn, faultn);
      end
      $display("*** PASSED ***");
      $finish;
    end
  end

  // Watchdog
  initial begin
    wait (limit_cycles > 0);
    #(limit_cycles * clk_period);
    $display("timeout, the test records did not complete within %0d cycles", limit_cycles);
    stop_with_failure();
  end

endmodule

// File: testbench/stepper_tests.txt
# step dir en cmp_a cmp_b off_time fast_thr blank min_on inv_h inv_l hold
#   then expected phase_ct gate_h gate_l faultn; all hex except hold (decimal cycles)
# Reset state, then enable
0 0 0 0 0 040 030 08 04 0 0 2  00 0 f 1
0 0 1 0 0 040 030 08 04 0 0 3  00 a 5 1
# Step up once, then down twice into quadrant 11
1 1 1 0 0 040 030 08 04 0 0 4  01 a 5 1
0 1 1 0 0 040 030 08 04 0 0 4  01 a 5 1
1 0 1 0 0 040 030 08 04 0 0 4  00 a 5 1
0 0 1 0 0 040 030 08 04 0 0 4  00 a 5 1
1 0 1 0 0 040 030 08 04 0 0 4  ff 6 9 1
0 0 1 0 0 040 030 08 04 0 0 12 ff 6 9 1
# Coil A trip: fast decay, slow decay, back to drive
0 0 1 1 0 040 030 08 04 0 0 4  ff a 5 1
0 0 1 0 0 040 030 08 04 0 0 20 ff 2 d 1
0 0 1 0 0 040 030 08 04 0 0 50 ff 6 9 1
# Output inversion
0 0 1 0 0 040 030 08 04 1 0 2  ff 9 9 1
0 0 1 0 0 040 030 08 04 0 1 2  ff 6 6 1
0 0 1 0 0 040 030 08 04 1 1 2  ff 9 6 1
# Disable, then enable again
0 0 0 0 0 040 030 08 04 0 0 3  ff 0 f 1
0 0 1 0 0 040 030 08 04 0 0 3  ff 6 9 1
# Retrip inside the minimum on time latches the fault
0 0 1 1 0 040 030 04 20 0 0 80 ff 0 5 0
0 0 1 0 0 040 030 04 20 0 0 60 ff 0 9 0
1 1 1 0 0 040 030 04 20 0 0 4  00 0 5 0
0 1 0 0 0 040 030 04 20 0 0 3  00 0 f 0

// File: vlog.f
verilog/stepper_pkg.sv
verilog/coil_timer_if.sv
verilog/step_decode.sv
verilog/coil_chopper.sv
verilog/bridge_driver.sv
verilog/stepper_top.sv
testbench/stepper_tb.sv
